/* files.f */
+incdir+sim
verilog/cache_pkg.sv
verilog/mem_pkg.sv
verilog/sdp_ram.sv
verilog/cache_way.sv
verilog/replace_state.sv
verilog/dcache.sv
verilog/line_memory.sv
verilog/dcache_top.sv
sim/tb_dcache_top.sv

/* run_sim.sh */
#!/bin/sh
# build the dcache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f files.f --top-module tb_dcache_top --Mdir obj_dir -o tb_dcache_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_dcache_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* sim/tb_cases.svh */
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

typedef struct packed {
    logic        is_store;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] exp_rdata;
    logic        exp_miss;
} case_t;

case_t case_q [$];
string name_q [$];

// tag | index | word | byte
function automatic logic [31:0] make_addr(input int tag, input int index, input int word);
    return {tag[19:0], index[6:0], word[2:0], 2'b00};
endfunction

function automatic void add_case(input string name, input logic is_store, input logic [31:0] a,
                                 input logic [31:0] d, input logic [3:0] s,
                                 input logic [31:0] exp_rdata, input logic exp_miss);
    case_t c;
    c = '{is_store, a, d, s, exp_rdata, exp_miss};
    case_q.push_back(c);
    name_q.push_back(name);
endfunction

function automatic void load_cases();
    add_case("load_cold_miss",     1'b0, make_addr(1, 5, 0), 32'h0, 4'h0, 32'h0, 1'b1);
    add_case("load_reload_hit",    1'b0, make_addr(1, 5, 0), 32'h0, 4'h0, 32'h0, 1'b0);
    add_case("store_word_miss",    1'b1, make_addr(2, 6, 3), 32'hdead_beef, 4'hf, 32'h0, 1'b1);
    add_case("load_stored_word",   1'b0, make_addr(2, 6, 3), 32'h0, 4'h0, 32'hdead_beef, 1'b0);
    // lanes 0 and 2 only
    add_case("store_byte_lanes",   1'b1, make_addr(2, 6, 3), 32'h1122_3344, 4'b0101, 32'h0, 1'b0);
    add_case("load_partial_merge", 1'b0, make_addr(2, 6, 3), 32'h0, 4'h0, 32'hde22_be44, 1'b0);
    add_case("store_half_miss",    1'b1, make_addr(3, 6, 1), 32'haabb_ccdd, 4'b1100, 32'h0, 1'b1);
    add_case("load_half_merge",    1'b0, make_addr(3, 6, 1), 32'h0, 4'h0, 32'haabb_0000, 1'b0);
    // dirty eviction in set 9
    add_case("store_tag_a",        1'b1, make_addr(1, 9, 2), 32'h0a0a_0a0a, 4'hf, 32'h0, 1'b1);
    add_case("store_tag_b",        1'b1, make_addr(2, 9, 2), 32'h0b0b_0b0b, 4'hf, 32'h0, 1'b1);
    add_case("load_tag_c_evict",   1'b0, make_addr(3, 9, 2), 32'h0, 4'h0, 32'h0, 1'b1);
    add_case("load_evicted_a",     1'b0, make_addr(1, 9, 2), 32'h0, 4'h0, 32'h0a0a_0a0a, 1'b1);
    add_case("load_evicted_b",     1'b0, make_addr(2, 9, 2), 32'h0, 4'h0, 32'h0b0b_0b0b, 1'b1);
    // A, B, A, C leaves B as the victim
    add_case("lru_load_a",         1'b0, make_addr(4, 12, 0), 32'h0, 4'h0, 32'h0, 1'b1);
    add_case("lru_load_b",         1'b0, make_addr(5, 12, 0), 32'h0, 4'h0, 32'h0, 1'b1);
    add_case("lru_touch_a",        1'b0, make_addr(4, 12, 0), 32'h0, 4'h0, 32'h0, 1'b0);
    add_case("lru_load_c",         1'b0, make_addr(6, 12, 0), 32'h0, 4'h0, 32'h0, 1'b1);
    add_case("lru_hit_a",          1'b0, make_addr(4, 12, 0), 32'h0, 4'h0, 32'h0, 1'b0);
    add_case("lru_miss_b",         1'b0, make_addr(5, 12, 0), 32'h0, 4'h0, 32'h0, 1'b1);
endfunction

`endif

/* sim/tb_dcache_top.sv */
`timescale 1ns/10ps

module tb_dcache_top;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int RAND_NUM     = 200;
    localparam int MEM_DEPTH    = 1024;   // 8 tags per set before aliasing
    localparam int RD_LATENCY   = 4;

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         req_valid;
    logic                         op;
    logic [cache_pkg::ADDR_W-1:0] addr;
    cache_pkg::word_t             wdata;
    logic [3:0]                   wstrb;
    logic                         addr_ok, data_ok, stall, cache_miss;
    cache_pkg::word_t             rdata;

    integer seed = 31566;
    bit     table_ready = 1'b0;
    int     rand_sets [3] = '{3, 9, 100};

    // bytes of tags 0..7 plus tag and lru state of every set
    logic [7:0]  ref_mem [32768];
    logic [1:0]  ref_valid [cache_pkg::SET_NUM];
    logic [19:0] ref_tag [cache_pkg::SET_NUM][2];
    logic        ref_lru [cache_pkg::SET_NUM];

    `include "tb_cases.svh"

    dcache_top #(
        .MEM_DEPTH  (MEM_DEPTH),
        .RD_LATENCY (RD_LATENCY)
    ) u_dut (
        .clk, .reset,
        .req_valid, .op, .addr, .wdata, .wstrb,
        .addr_ok, .data_ok, .rdata, .stall, .cache_miss
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else
            stop_on_failure($sformatf("Error: %s %s expected %h actual %h",
                                      name, what, expected, actual));
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        logic [31:0] w;
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = ref_mem[{a[14:2], 2'(b)}];
        end
        return w;
    endfunction

    function automatic void apply_store(input logic [31:0] a, input logic [31:0] d,
                                        input logic [3:0] s);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) ref_mem[{a[14:2], 2'(b)}] = d[b*8 +: 8];
        end
    endfunction

    // lru bit of a set names the victim way
    function automatic logic predict_miss(input logic [31:0] a);
        logic [6:0]  idx;
        logic [19:0] tag;
        logic        way;
        idx = a[11:5];
        tag = a[31:12];
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
                ref_lru[idx] = (w == 0);
                return 1'b0;
            end
        end
        way = ref_lru[idx];
        ref_valid[idx][way] = 1'b1;
        ref_tag[idx][way] = tag;
        ref_lru[idx] = ~way;
        return 1'b1;
    endfunction

    task automatic run_request(input string name, input logic is_store, input logic [31:0] a,
                               input logic [31:0] d, input logic [3:0] s,
                               input logic [31:0] exp_rdata, input logic exp_miss);
        while (stall !== 1'b0) @(negedge clk);
        req_valid = 1'b1;
        op        = is_store;
        addr      = a;
        wdata     = d;
        wstrb     = s;
        #1;
        check_value(name, "addr_ok", 32'(1'b1), 32'(addr_ok));
        @(negedge clk);
        req_valid = 1'b0;
        check_value(name, "cache_miss", 32'(exp_miss), 32'(cache_miss));
        check_value(name, "stall", 32'(exp_miss), 32'(stall));   // high only on a miss
        check_value(name, "data_ok", 32'(!exp_miss), 32'(data_ok));
        while (data_ok !== 1'b1) @(negedge clk);
        check_value(name, "stall at data_ok", 32'(1'b0), 32'(stall));
        if (!is_store) check_value(name, "rdata", exp_rdata, rdata);
    endtask

    initial begin : main
        case_t       tc;
        logic [31:0] r, d, a, exp_rdata;
        logic        exp_miss;
        reset     = 1'b1;
        req_valid = 1'b0;
        op        = 1'b0;
        addr      = '0;
        wdata     = '0;
        wstrb     = '0;
        for (int i = 0; i < 32768; i++) ref_mem[i] = '0;
        for (int i = 0; i < cache_pkg::SET_NUM; i++) begin
            ref_valid[i] = '0;
            ref_lru[i]   = 1'b0;
            ref_tag[i][0] = '0;
            ref_tag[i][1] = '0;
        end
        load_cases();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < case_q.size(); i++) begin
            tc = case_q[i];
            void'(predict_miss(tc.addr));   // keeps the model in step
            run_request(name_q[i], tc.is_store, tc.addr, tc.wdata, tc.wstrb,
                        tc.exp_rdata, tc.exp_miss);
            if (tc.is_store) apply_store(tc.addr, tc.wdata, tc.wstrb);
        end

        for (int i = 0; i < RAND_NUM; i++) begin
            r = $random(seed);
            d = $random(seed);
            a = make_addr(int'(r[2:1]), rand_sets[r[17:10] % 8'd3], int'(r[5:3]));
            exp_rdata = expected_word(a);
            exp_miss  = predict_miss(a);
            run_request($sformatf("random_%0d", i), r[0], a, d, r[9:6], exp_rdata, exp_miss);
            if (r[0]) apply_store(a, d, r[9:6]);
        end

        $display("Regression passed");
        $finish;
    end

    initial begin : watchdog
        longint limit_ns;
        wait (table_ready);
        limit_ns = longint'(case_q.size() + RAND_NUM + RESET_CYCLES)
                 * (RD_LATENCY + 12) * CLK_PERIOD;
        #(limit_ns);
        stop_on_failure($sformatf("timeout: data_ok never arrived within %0d ns", limit_ns));
    end

endmodule

/* verilog/cache_pkg.sv */
package cache_pkg;

    // address and data widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // address split: tag | index | offset
    localparam int OFFSET_W = 5;
    localparam int INDEX_W  = 7;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // organization
    localparam int BANK_NUM = 8;    // words per line
    localparam int SET_NUM  = 128;

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [DATA_W-1:0]  word_t;

    // valid sits above the tag, 21 bits in all
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

endpackage

/* verilog/cache_way.sv */
`timescale 1ns/10ps

module cache_way (
    input  logic                                         clk,
    input  cache_pkg::index_t                            raddr,
    input  cache_pkg::index_t                            waddr,
    input  logic [cache_pkg::BANK_NUM*cache_pkg::DATA_W/8-1:0] data_we,
    input  mem_pkg::line_t                               line_wdata,
    input  logic                                         tag_we,
    input  cache_pkg::tagv_t                             tag_wdata,
    output mem_pkg::line_t                               line_rdata,
    output cache_pkg::tagv_t                             tagv
);

    localparam int BYTE_NUM = cache_pkg::DATA_W / 8;
    localparam int DATA_W   = cache_pkg::DATA_W;

    cache_pkg::word_t bank_rdata [cache_pkg::BANK_NUM];

    // one bank per word of the line, byte lanes per bank
    for (genvar b = 0; b < cache_pkg::BANK_NUM; b++) begin : g_bank
        sdp_ram #(
            .word_t (cache_pkg::word_t),
            .LANES  (BYTE_NUM),
            .DEPTH  (cache_pkg::SET_NUM)
        ) u_bank (
            .clk   (clk),
            .we    (data_we[b*BYTE_NUM +: BYTE_NUM]),
            .waddr (waddr),
            .wdata (line_wdata[b*DATA_W +: DATA_W]),
            .raddr (raddr),
            .rdata (bank_rdata[b])
        );
    end

    always_comb begin
        for (int b = 0; b < cache_pkg::BANK_NUM; b++) begin
            line_rdata[b*DATA_W +: DATA_W] = bank_rdata[b];
        end
    end

    sdp_ram #(
        .word_t (cache_pkg::tagv_t),
        .LANES  (1),
        .DEPTH  (cache_pkg::SET_NUM)
    ) u_tagv (
        .clk   (clk),
        .we    (tag_we),
        .waddr (waddr),
        .wdata (tag_wdata),
        .raddr (raddr),
        .rdata (tagv)
    );

endmodule

/* verilog/dcache.sv */
`timescale 1ns/10ps

module dcache (
    input  logic                                 clk,
    input  logic                                 reset,
    // processor side
    input  logic                                 req_valid,
    input  logic                                 op,
    input  logic [cache_pkg::ADDR_W-1:0]         addr,
    input  cache_pkg::word_t                     wdata,
    input  logic [cache_pkg::DATA_W/8-1:0]       wstrb,
    output logic                                 addr_ok,
    output logic                                 data_ok,
    output cache_pkg::word_t                     rdata,
    output logic                                 stall,
    output logic                                 cache_miss,
    // line memory side
    output logic                                 rd_req,
    output logic [mem_pkg::LINE_ADDR_W-1:0]      rd_addr,
    input  logic                                 rd_rdy,
    input  logic                                 ret_valid,
    input  mem_pkg::line_t                       ret_data,
    output logic                                 wr_req,
    output logic [mem_pkg::LINE_ADDR_W-1:0]      wr_addr,
    output mem_pkg::line_t                       wr_data,
    input  logic                                 wr_rdy
);

    localparam int DATA_W     = cache_pkg::DATA_W;
    localparam int BYTE_NUM   = DATA_W / 8;
    localparam int LINE_BYTES = cache_pkg::BANK_NUM * BYTE_NUM;
    localparam int WORD_SEL_W = $clog2(cache_pkg::BANK_NUM);

    typedef enum logic [2:0] {
        s_idle, s_writeback, s_refill_req, s_refill_wait, s_finish
    } state_t;

    state_t state, state_next;

    logic                        req_valid_r;
    logic                        req_op;
    cache_pkg::tag_t             req_tag;
    cache_pkg::index_t           req_index;
    logic [WORD_SEL_W-1:0]       req_word;
    cache_pkg::word_t            req_wdata;
    logic [BYTE_NUM-1:0]         req_wstrb;

    mem_pkg::line_t              way_line [2];
    cache_pkg::tagv_t            way_tagv [2];
    logic [1:0]                  way_hit;
    logic [LINE_BYTES-1:0]       way_data_we [2];
    mem_pkg::line_t              hit_line, fill_line;
    logic [LINE_BYTES-1:0]       store_we;
    logic                        lookup, hit, miss, store_hit, refill_we;
    logic                        victim, victim_dirty;
    cache_pkg::word_t            refill_word;

    // request register, held while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid_r <= 1'b0;
        end else if (!stall) begin
            req_valid_r <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            req_op    <= op;
            req_tag   <= addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
            req_index <= addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
            req_word  <= addr[$clog2(BYTE_NUM) +: WORD_SEL_W];
            req_wdata <= wdata;
            req_wstrb <= wstrb;
        end
    end

    assign lookup    = req_valid_r && state == s_idle;
    assign hit       = lookup && |way_hit;
    assign miss      = lookup && !(|way_hit);
    assign store_hit = hit && req_op;
    assign refill_we = state == s_refill_wait && ret_valid;
    assign store_we  = LINE_BYTES'(req_wstrb) << (req_word * BYTE_NUM);

    // refill line with the pending store merged in by byte
    always_comb begin
        fill_line = ret_data;
        for (int b = 0; b < BYTE_NUM; b++) begin
            if (req_op && req_wstrb[b]) begin
                fill_line[req_word*DATA_W + b*8 +: 8] = req_wdata[b*8 +: 8];
            end
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign way_hit[w] = way_tagv[w].valid && way_tagv[w].tag == req_tag;
        assign way_data_we[w] = (refill_we && victim == 1'(w)) ? '1 :
                                (store_hit && way_hit[w]) ? store_we : '0;

        cache_way u_way (
            .clk        (clk),
            .raddr      (stall ? req_index : addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W]),
            .waddr      (req_index),
            .data_we    (way_data_we[w]),
            .line_wdata (fill_line),
            .tag_we     (refill_we && victim == 1'(w)),
            .tag_wdata  ({1'b1, req_tag}),
            .line_rdata (way_line[w]),
            .tagv       (way_tagv[w])
        );
    end

    replace_state u_replace (
        .clk          (clk),
        .reset        (reset),
        .index        (req_index),
        .touch        (hit || refill_we),
        .touch_way    (refill_we ? victim : way_hit[1]),
        .set_dirty    (store_hit || (refill_we && req_op)),
        .clear_dirty  (refill_we && !req_op),
        .dirty_way    (refill_we ? victim : way_hit[1]),
        .victim       (victim),
        .victim_dirty (victim_dirty)
    );

    always_ff @(posedge clk) begin
        if (refill_we) begin
            refill_word <= fill_line[req_word*DATA_W +: DATA_W];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) state <= s_idle;
        else       state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle:        if (miss) state_next = victim_dirty ? s_writeback : s_refill_req;
            s_writeback:   if (wr_rdy) state_next = s_refill_req;
            s_refill_req:  if (rd_rdy) state_next = s_refill_wait;
            s_refill_wait: if (ret_valid) state_next = s_finish;
            default:       state_next = s_idle;
        endcase
    end

    // victim line goes out under its own tag
    assign wr_req  = state == s_writeback && wr_rdy;
    assign wr_addr = {way_tagv[victim].tag, req_index};
    assign wr_data = way_line[victim];
    assign rd_req  = state == s_refill_req && rd_rdy;
    assign rd_addr = {req_tag, req_index};

    assign hit_line   = way_line[way_hit[1]];
    assign stall      = miss || state inside {s_writeback, s_refill_req, s_refill_wait};
    assign addr_ok    = req_valid && !stall;
    assign data_ok    = hit || state == s_finish;
    assign cache_miss = miss;
    assign rdata      = state == s_finish ? refill_word : hit_line[req_word*DATA_W +: DATA_W];

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top #(
    parameter int MEM_DEPTH  = 256,
    parameter int RD_LATENCY = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req_valid,
    input  logic                           op,
    input  logic [cache_pkg::ADDR_W-1:0]   addr,
    input  cache_pkg::word_t               wdata,
    input  logic [cache_pkg::DATA_W/8-1:0] wstrb,
    output logic                           addr_ok,
    output logic                           data_ok,
    output cache_pkg::word_t               rdata,
    output logic                           stall,
    output logic                           cache_miss
);

    logic                            rd_req, rd_rdy, ret_valid, wr_req, wr_rdy;
    logic [mem_pkg::LINE_ADDR_W-1:0] rd_addr, wr_addr;
    mem_pkg::line_t                  ret_data, wr_data;

    dcache u_dcache (
        .clk, .reset,
        .req_valid, .op, .addr, .wdata, .wstrb,
        .addr_ok, .data_ok, .rdata, .stall, .cache_miss,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    line_memory #(
        .MEM_DEPTH  (MEM_DEPTH),
        .RD_LATENCY (RD_LATENCY)
    ) u_mem (
        .clk, .reset,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

endmodule

/* verilog/line_memory.sv */
`timescale 1ns/10ps

module line_memory #(
    parameter int MEM_DEPTH  = 256,
    parameter int RD_LATENCY = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rd_req,
    input  logic [mem_pkg::LINE_ADDR_W-1:0] rd_addr,
    output logic                            rd_rdy,
    output logic                            ret_valid,
    output mem_pkg::line_t                  ret_data,
    input  logic                            wr_req,
    input  logic [mem_pkg::LINE_ADDR_W-1:0] wr_addr,
    input  mem_pkg::line_t                  wr_data,
    output logic                            wr_rdy
);

    localparam int MEM_AW = $clog2(MEM_DEPTH);
    localparam int CNT_W  = 4;   // covers latencies up to 15

    mem_pkg::line_t     mem [MEM_DEPTH];
    logic               busy;
    logic [CNT_W-1:0]   cnt;
    logic [MEM_AW-1:0]  rd_index;

    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (rd_req && rd_rdy) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(RD_LATENCY - 1);
        end else if (busy) begin
            if (cnt == '0) busy <= 1'b0;   // return cycle
            else           cnt  <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req && rd_rdy) rd_index <= rd_addr[MEM_AW-1:0];
        if (wr_req && wr_rdy) mem[wr_addr[MEM_AW-1:0]] <= wr_data;
    end

    assign rd_rdy    = !busy;
    assign wr_rdy    = !busy;
    assign ret_valid = busy && cnt == '0;
    assign ret_data  = mem[rd_index];

endmodule

/* verilog/mem_pkg.sv */
package mem_pkg;

    // one full cache line per transfer
    localparam int LINE_W = cache_pkg::BANK_NUM * cache_pkg::DATA_W;

    // line address drops the byte offset
    localparam int LINE_ADDR_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W;

    typedef logic [LINE_W-1:0] line_t;

endpackage

/* verilog/replace_state.sv */
`timescale 1ns/10ps

module replace_state (
    input  logic              clk,
    input  logic              reset,
    input  cache_pkg::index_t index,
    input  logic              touch,
    input  logic              touch_way,
    input  logic              set_dirty,
    input  logic              clear_dirty,
    input  logic              dirty_way,
    output logic              victim,
    output logic              victim_dirty
);

    // lru bit names the way to evict next
    logic [cache_pkg::SET_NUM-1:0]      lru;
    logic [cache_pkg::SET_NUM-1:0][1:0] dirty;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (touch) begin
            lru[index] <= ~touch_way;   // other way becomes the oldest
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dirty <= '0;
        end else if (set_dirty) begin
            dirty[index][dirty_way] <= 1'b1;
        end else if (clear_dirty) begin
            dirty[index][dirty_way] <= 1'b0;
        end
    end

    assign victim       = lru[index];
    assign victim_dirty = dirty[index][victim];

endmodule

/* verilog/sdp_ram.sv */
`timescale 1ns/10ps

module sdp_ram #(
    parameter type word_t = logic [31:0],
    parameter int  LANES  = 4,
    parameter int  DEPTH  = 128
) (
    input  logic                     clk,
    input  logic [LANES-1:0]         we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  word_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output word_t                    rdata
);

    localparam int LANE_W = $bits(word_t) / LANES;

    word_t mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (we[l]) begin
                mem[waddr][l*LANE_W +: LANE_W] <= wdata[l*LANE_W +: LANE_W];
            end
            // same address collision returns the new lane
            if (we[l] && waddr == raddr) begin
                rdata[l*LANE_W +: LANE_W] <= wdata[l*LANE_W +: LANE_W];
            end else begin
                rdata[l*LANE_W +: LANE_W] <= mem[raddr][l*LANE_W +: LANE_W];
            end
        end
    end

endmodule
